// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pad_subsystem
FILELIST = pad_subsystem.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// File: pad_subsystem.f
source/pad_pkg.sv
source/pad_cfg_regs.sv
source/pad_mux.sv
source/pad_subsystem.sv
verification/pad_subsystem_sva.sv
verification/tb_pad_subsystem.sv

// File: source/pad_cfg_regs.sv
// Wishbone classic slave holding the per-pad mux select and configuration word
// Pad i lives at byte address 4*i; other addresses are acked and read as zero
`default_nettype none

module pad_cfg_regs (
  input  logic                     ref_clk_i,
  input  logic                     reset_i,
  input  pad_pkg::wb_req_t         wb_req_i,
  output pad_pkg::wb_rsp_t         wb_rsp_o,
  output pad_pkg::pad_ctrl_array_t pad_ctrl_o
);

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_WAIT,
    WB_ACK
  } wb_state_t;

  localparam int ADR_HI_LSB = pad_pkg::REG_IDX_LSB + pad_pkg::PAD_IDX_WIDTH;

  wb_state_t                state_q;
  wb_state_t                state_d;
  logic                     req_active;
  logic                     adr_valid;
  logic                     wr_en;
  logic                     ack;
  pad_pkg::pad_idx_t        pad_idx;
  pad_pkg::wb_data_t        rd_data;
  pad_pkg::pad_ctrl_array_t pad_ctrl_q;

  assign req_active = wb_req_i.cyc && wb_req_i.stb;

  // Word index and upper-bit decode
  assign pad_idx   = wb_req_i.adr[pad_pkg::REG_IDX_LSB +: pad_pkg::PAD_IDX_WIDTH];
  assign adr_valid = (wb_req_i.adr[pad_pkg::WB_ADDR_WIDTH-1:ADR_HI_LSB] == '0);

  // Request sampled in WAIT and acked one clock later
  always_comb begin
    state_d = state_q;
    case (state_q)
      WB_IDLE: begin
        if (req_active) begin
          state_d = WB_WAIT;
        end
      end
      WB_WAIT: begin
        if (req_active) begin
          state_d = WB_ACK;
        end else begin
          state_d = WB_IDLE;
        end
      end
      WB_ACK: begin
        state_d = WB_IDLE;
      end
      default: begin
        state_d = WB_IDLE;
      end
    endcase
  end

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Register update lands on the edge that raises ack
  assign wr_en = (state_q == WB_WAIT) && req_active && wb_req_i.we && adr_valid;

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < pad_pkg::N_IO; i++) begin
        pad_ctrl_q[i].sel <= pad_pkg::PAD_SEL_GPIO;
        pad_ctrl_q[i].cfg <= '0;
      end
    end else if (wr_en) begin
      pad_ctrl_q[pad_idx].sel <=
        pad_pkg::pad_sel_t'(wb_req_i.dat[pad_pkg::REG_SEL_LSB +: pad_pkg::NBIT_PADMUX]);
      pad_ctrl_q[pad_idx].cfg <= wb_req_i.dat[pad_pkg::REG_CFG_LSB +: pad_pkg::NBIT_PADCFG];
    end
  end

  // Read word with unused bits zero
  always_comb begin
    rd_data = '0;
    if (adr_valid) begin
      rd_data[pad_pkg::REG_SEL_LSB +: pad_pkg::NBIT_PADMUX] = pad_ctrl_q[pad_idx].sel;
      rd_data[pad_pkg::REG_CFG_LSB +: pad_pkg::NBIT_PADCFG] = pad_ctrl_q[pad_idx].cfg;
    end
  end

  assign ack          = (state_q == WB_ACK);
  assign wb_rsp_o.ack = ack;
  assign wb_rsp_o.dat = ack ? rd_data : '0;

  assign pad_ctrl_o = pad_ctrl_q;

endmodule

`default_nettype wire

// File: source/pad_mux.sv
// Routes GPIO, peripheral or FPGA function banks onto each pad by its mux select
// Pad inputs pass a two-flop synchronizer and are steered back to the selected bank
`default_nettype none

module pad_mux (
  input  logic                                          ref_clk_i,
  input  logic                                          reset_i,
  input  pad_pkg::pad_ctrl_array_t                      pad_ctrl_i,
  input  pad_pkg::func_bank_t                           gpio_i,
  input  pad_pkg::func_bank_t                           perio_i,
  input  pad_pkg::func_bank_t                           fpgaio_i,
  input  pad_pkg::pad_vec_t                             io_in_i,
  output pad_pkg::pad_vec_t                             io_out_o,
  output pad_pkg::pad_vec_t                             io_oe_o,
  output pad_pkg::pad_vec_t                             gpio_in_o,
  output pad_pkg::pad_vec_t                             perio_in_o,
  output pad_pkg::pad_vec_t                             fpgaio_in_o,
  output pad_pkg::pad_cfg_word_t [pad_pkg::N_IO-1:0]    pad_cfg_o
);

  pad_pkg::pad_vec_t sync_q1;
  pad_pkg::pad_vec_t sync_q2;

  // Purely combinational output side
  always_comb begin
    for (int i = 0; i < pad_pkg::N_IO; i++) begin
      case (pad_ctrl_i[i].sel)
        pad_pkg::PAD_SEL_GPIO: begin
          io_out_o[i] = gpio_i.out[i];
          io_oe_o[i]  = gpio_i.oe[i];
        end
        pad_pkg::PAD_SEL_PERIO: begin
          io_out_o[i] = perio_i.out[i];
          io_oe_o[i]  = perio_i.oe[i];
        end
        pad_pkg::PAD_SEL_FPGAIO: begin
          io_out_o[i] = fpgaio_i.out[i];
          io_oe_o[i]  = fpgaio_i.oe[i];
        end
        default: begin
          // Unconnected pad
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

  // Two-stage input synchronizer
  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= io_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // Only the selected bank sees the pad and the others read zero
  always_comb begin
    for (int i = 0; i < pad_pkg::N_IO; i++) begin
      gpio_in_o[i]   = sync_q2[i] && (pad_ctrl_i[i].sel == pad_pkg::PAD_SEL_GPIO);
      perio_in_o[i]  = sync_q2[i] && (pad_ctrl_i[i].sel == pad_pkg::PAD_SEL_PERIO);
      fpgaio_in_o[i] = sync_q2[i] && (pad_ctrl_i[i].sel == pad_pkg::PAD_SEL_FPGAIO);
    end
  end

  always_comb begin
    for (int i = 0; i < pad_pkg::N_IO; i++) begin
      pad_cfg_o[i] = pad_ctrl_i[i].cfg;
    end
  end

endmodule

`default_nettype wire

// File: source/pad_pkg.sv
// Shared pad-control definitions for pad counts, bus widths, select encoding and structs
// Referenced by scoped names from the register block, the pad mux and the top level
`default_nettype none

package pad_pkg;

  // Pad and field sizes
  localparam int N_IO          = 8;
  localparam int NBIT_PADMUX   = 2;
  localparam int NBIT_PADCFG   = 6;

  // Wishbone bus sizes
  localparam int WB_ADDR_WIDTH = 8;
  localparam int WB_DATA_WIDTH = 32;

  // Pad register layout with one 32-bit word per pad
  localparam int REG_SEL_LSB   = 0;
  localparam int REG_CFG_LSB   = 8;
  localparam int REG_IDX_LSB   = 2;
  localparam int PAD_IDX_WIDTH = $clog2(N_IO);

  typedef logic [N_IO-1:0]          pad_vec_t;
  typedef logic [NBIT_PADCFG-1:0]   pad_cfg_word_t;
  typedef logic [PAD_IDX_WIDTH-1:0] pad_idx_t;
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

  typedef enum logic [NBIT_PADMUX-1:0] {
    PAD_SEL_GPIO   = 2'd0,
    PAD_SEL_PERIO  = 2'd1,
    PAD_SEL_FPGAIO = 2'd2,
    PAD_SEL_NONE   = 2'd3
  } pad_sel_t;

  typedef struct packed {
    pad_sel_t      sel;
    pad_cfg_word_t cfg;
  } pad_ctrl_t;

  typedef pad_ctrl_t [N_IO-1:0] pad_ctrl_array_t;

  // One function bank driving all pads
  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
  } func_bank_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: source/pad_subsystem.sv
// Pad control top level with the Wishbone register block feeding the pad mux
// Function banks and pad vectors connect straight to the ports
`default_nettype none

module pad_subsystem (
  input  logic                                       ref_clk_i,
  input  logic                                       reset_i,
  input  pad_pkg::wb_req_t                           wb_req_i,
  output pad_pkg::wb_rsp_t                           wb_rsp_o,
  input  pad_pkg::func_bank_t                        gpio_i,
  input  pad_pkg::func_bank_t                        perio_i,
  input  pad_pkg::func_bank_t                        fpgaio_i,
  input  pad_pkg::pad_vec_t                          io_in_i,
  output pad_pkg::pad_vec_t                          io_out_o,
  output pad_pkg::pad_vec_t                          io_oe_o,
  output pad_pkg::pad_vec_t                          gpio_in_o,
  output pad_pkg::pad_vec_t                          perio_in_o,
  output pad_pkg::pad_vec_t                          fpgaio_in_o,
  output pad_pkg::pad_cfg_word_t [pad_pkg::N_IO-1:0] pad_cfg_o
);

  pad_pkg::pad_ctrl_array_t s_pad_ctrl;

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i  (ref_clk_i),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .pad_ctrl_o (s_pad_ctrl)
  );

  pad_mux i_pad_mux (
    .ref_clk_i   (ref_clk_i),
    .reset_i     (reset_i),
    .pad_ctrl_i  (s_pad_ctrl),
    .gpio_i      (gpio_i),
    .perio_i     (perio_i),
    .fpgaio_i    (fpgaio_i),
    .io_in_i     (io_in_i),
    .io_out_o    (io_out_o),
    .io_oe_o     (io_oe_o),
    .gpio_in_o   (gpio_in_o),
    .perio_in_o  (perio_in_o),
    .fpgaio_in_o (fpgaio_in_o),
    .pad_cfg_o   (pad_cfg_o)
  );

endmodule

`default_nettype wire

// File: verification/pad_cases.txt
// Columns: op _ arg_a _ arg_b (hex). op 1 write adr/data, 2 read adr/expected data,
// 3 bank drive with 2-bit pad selects in arg_b[15:0], 4 io_in arg_a, expected gpio/perio/fpgaio
2_00_00000000
2_04_00000000
2_08_00000000
2_0c_00000000
2_10_00000000
2_14_00000000
2_18_00000000
2_1c_00000000
3_00_00000000
4_a5_00a50000
1_00_00002a01
2_00_00002a01
1_04_00001502
2_04_00001502
1_08_00003f03
2_08_00003f03
1_0c_ffffea01
2_0c_00002a01
1_1c_00000102
2_1c_00000102
3_00_00008079
3_00_00008079
4_ff_00700982
4_5a_00500802
1_20_00003f03
2_20_00000000
1_e4_00000002
2_e4_00000000
2_00_00002a01
2_04_00001502
3_00_00008079
1_00_00000000
2_00_00000000
3_00_00008078

// File: verification/pad_subsystem_sva.sv
// Wishbone handshake checks for the pad subsystem
// Bound into every pad_subsystem instance
`default_nettype none

module pad_subsystem_sva (
  input logic             ref_clk_i,
  input logic             reset_i,
  input pad_pkg::wb_req_t wb_req_i,
  input pad_pkg::wb_rsp_t wb_rsp_i
);

  // Ack is a single pulse
  ack_one_cycle: assert property (@(posedge ref_clk_i) disable iff (reset_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack stayed high for more than one cycle");

  ack_inside_request: assert property (@(posedge ref_clk_i) disable iff (reset_i)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("ack raised without cyc and stb");

  // First reset edge clears the slave state
  ack_low_in_reset: assert property (@(posedge ref_clk_i)
    (reset_i && $past(reset_i)) |-> !wb_rsp_i.ack)
    else $error("ack high during reset");

endmodule

bind pad_subsystem pad_subsystem_sva i_pad_subsystem_sva (
  .ref_clk_i (ref_clk_i),
  .reset_i   (reset_i),
  .wb_req_i  (wb_req_i),
  .wb_rsp_i  (wb_rsp_o)
);

`default_nettype wire

// File: verification/tb_pad_subsystem.sv
// Testbench for the pad subsystem, replaying verification/pad_cases.txt
// Run from the project root; each case is a Wishbone access, a bank drive or a pad input drive
`default_nettype none

module tb_pad_subsystem;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int MAX_CASES       = 64;
  localparam int WB_WAIT_MAX     = 4;
  localparam int CYCLES_PER_CASE = 20;
  localparam int TIMEOUT_MARGIN  = 50;

  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_READ  = 4'h2;
  localparam logic [3:0] OP_BANK  = 4'h3;
  localparam logic [3:0] OP_INPUT = 4'h4;

  logic                                       ref_clk;
  logic                                       reset;
  pad_pkg::wb_req_t                           wb_req;
  pad_pkg::wb_rsp_t                           wb_rsp;
  pad_pkg::func_bank_t                        gpio;
  pad_pkg::func_bank_t                        perio;
  pad_pkg::func_bank_t                        fpgaio;
  pad_pkg::pad_vec_t                          io_in;
  pad_pkg::pad_vec_t                          io_out;
  pad_pkg::pad_vec_t                          io_oe;
  pad_pkg::pad_vec_t                          gpio_in;
  pad_pkg::pad_vec_t                          perio_in;
  pad_pkg::pad_vec_t                          fpgaio_in;
  pad_pkg::pad_cfg_word_t [pad_pkg::N_IO-1:0] pad_cfg;

  logic [43:0] case_mem [MAX_CASES];
  int          n_cases;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          cycle_limit;

  pad_subsystem i_pad_subsystem (
    .ref_clk_i   (ref_clk),
    .reset_i     (reset),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .gpio_i      (gpio),
    .perio_i     (perio),
    .fpgaio_i    (fpgaio),
    .io_in_i     (io_in),
    .io_out_o    (io_out),
    .io_oe_o     (io_oe),
    .gpio_in_o   (gpio_in),
    .perio_in_o  (perio_in),
    .fpgaio_in_o (fpgaio_in),
    .pad_cfg_o   (pad_cfg)
  );

  initial begin
    ref_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) ref_clk = ~ref_clk;
    end
  end

  // Limit is set once the case count is known
  always @(posedge ref_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  function automatic bit is_known_op(input logic [3:0] op);
    return (op == OP_WRITE) || (op == OP_READ) || (op == OP_BANK) || (op == OP_INPUT);
  endfunction

  // Classic cycle held through the edge that ends ack
  task automatic wb_transfer(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int   wait_cycles;
    logic acked;
    wait_cycles = 0;
    acked       = 1'b0;
    rdata       = '0;
    @(negedge ref_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    while (!acked && wait_cycles < WB_WAIT_MAX) begin
      @(negedge ref_clk);
      wait_cycles++;
      if (wb_rsp.ack) begin
        acked = 1'b1;
        rdata = wb_rsp.dat;
      end
    end
    if (!acked) begin
      $display("Wishbone request to address %h got no ack within %0d cycles", adr, WB_WAIT_MAX);
      error_count++;
    end else begin
      @(negedge ref_clk);
    end
    wb_req = '0;
  endtask

  task automatic read_and_check(input logic [7:0] adr, input logic [31:0] expected);
    logic [31:0] rdata;
    logic [2:0]  idx;
    wb_transfer(1'b0, adr, 32'h0, rdata);
    check_value("wb_rsp_o.dat", expected, rdata);
    // Valid pad address also forwards its configuration word
    if (adr[7:5] == 3'b000) begin
      idx = adr[4:2];
      check_value($sformatf("pad_cfg_o[%0d]", idx), 32'(expected[13:8]), 32'(pad_cfg[idx]));
    end
  endtask

  task automatic drive_banks(input logic [15:0] sel_pattern);
    logic [31:0]       rnd;
    logic [1:0]        sel;
    pad_pkg::pad_vec_t exp_out;
    pad_pkg::pad_vec_t exp_oe;
    @(negedge ref_clk);
    rnd    = $urandom;
    gpio   = rnd[15:0];
    rnd    = $urandom;
    perio  = rnd[15:0];
    rnd    = $urandom;
    fpgaio = rnd[15:0];
    for (int i = 0; i < pad_pkg::N_IO; i++) begin
      sel = sel_pattern[2*i +: 2];
      case (sel)
        pad_pkg::PAD_SEL_GPIO: begin
          exp_out[i] = gpio.out[i];
          exp_oe[i]  = gpio.oe[i];
        end
        pad_pkg::PAD_SEL_PERIO: begin
          exp_out[i] = perio.out[i];
          exp_oe[i]  = perio.oe[i];
        end
        pad_pkg::PAD_SEL_FPGAIO: begin
          exp_out[i] = fpgaio.out[i];
          exp_oe[i]  = fpgaio.oe[i];
        end
        default: begin
          exp_out[i] = 1'b0;
          exp_oe[i]  = 1'b0;
        end
      endcase
    end
    @(negedge ref_clk);
    check_value("io_out_o", 32'(exp_out), 32'(io_out));
    check_value("io_oe_o", 32'(exp_oe), 32'(io_oe));
  endtask

  // Two synchronizer edges before the banks see the new pattern
  task automatic drive_io_in(input logic [7:0] value, input logic [23:0] expected);
    @(negedge ref_clk);
    io_in = value;
    @(posedge ref_clk);
    @(posedge ref_clk);
    @(negedge ref_clk);
    check_value("gpio_in_o", 32'(expected[23:16]), 32'(gpio_in));
    check_value("perio_in_o", 32'(expected[15:8]), 32'(perio_in));
    check_value("fpgaio_in_o", 32'(expected[7:0]), 32'(fpgaio_in));
  endtask

  task automatic report_case(input int idx, input logic [3:0] op, input logic [7:0] arg_a,
                             input logic [31:0] arg_b, input bit ok);
    string verdict;
    verdict = ok ? "ok" : "error";
    case (op)
      OP_WRITE: $display("Case %0d write adr=%h dat=%h: %s", idx, arg_a, arg_b, verdict);
      OP_READ:  $display("Case %0d read adr=%h expect=%h: %s", idx, arg_a, arg_b, verdict);
      OP_BANK:  $display("Case %0d bank drive sel=%h: %s", idx, arg_b[15:0], verdict);
      default:  $display("Case %0d io_in=%h: %s", idx, arg_a, verdict);
    endcase
  endtask

  initial begin
    int          errors_before;
    logic [3:0]  op;
    logic [7:0]  arg_a;
    logic [31:0] arg_b;
    logic [31:0] unused_rdata;
    void'($urandom(69));
    reset     = 1'b1;
    wb_req    = '0;
    gpio      = '0;
    perio     = '0;
    fpgaio    = '0;
    io_in     = '0;

    $readmemh("verification/pad_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && is_known_op(case_mem[n_cases][43:40])) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      $display("No cases could be loaded from verification/pad_cases.txt");
      error_count++;
    end
    cycle_limit = n_cases * CYCLES_PER_CASE + TIMEOUT_MARGIN;

    repeat (RESET_CYCLES) @(posedge ref_clk);
    @(negedge ref_clk);
    reset = 1'b0;

    for (int k = 0; k < n_cases; k++) begin
      op            = case_mem[k][43:40];
      arg_a         = case_mem[k][39:32];
      arg_b         = case_mem[k][31:0];
      errors_before = error_count;
      case (op)
        OP_WRITE: wb_transfer(1'b1, arg_a, arg_b, unused_rdata);
        OP_READ:  read_and_check(arg_a, arg_b);
        OP_BANK:  drive_banks(arg_b[15:0]);
        default:  drive_io_in(arg_a, arg_b[23:0]);
      endcase
      if (error_count == errors_before) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      report_case(k, op, arg_a, arg_b, error_count == errors_before);
    end

    $display("Cases passed: %0d, failed: %0d", pass_count, fail_count);
    if (error_count == 0 && fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
